// ==== include/i2c_defs.svh ====
`ifndef I2C_DEFS_SVH
`define I2C_DEFS_SVH

// 7-bit addressing only
`define I2C_ADDR_WIDTH 7

// one frame on the wire, ack slot not counted
`define I2C_BYTE_WIDTH 8

// clock divider for the quarter-bit tick
`define I2C_DIVIDER_WIDTH 16

// each scl period is split into this many divider ticks
`define I2C_PHASES_PER_BIT 4

`endif

// ==== src/i2c_pkg.sv ====
`include "i2c_defs.svh"

package i2c_pkg;

    typedef logic [`I2C_ADDR_WIDTH-1:0] device_addr_t;
    typedef logic [`I2C_BYTE_WIDTH-1:0] data_byte_t;
    typedef logic [`I2C_DIVIDER_WIDTH-1:0] divider_t;

    // byte the sequencer is about to shift out
    typedef enum logic [1:0] {
        frame_addr_write,
        frame_register,
        frame_data,
        frame_addr_read
    } frame_sel_t;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_shift_out,
        st_check_ack,
        st_restart,
        st_shift_in,
        st_send_nack,
        st_send_stop
    } seq_state_t;

endpackage

// ==== src/i2c_request_decoder.sv ====
module i2c_request_decoder (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  enable,
    input  logic                  read_write,
    input  i2c_pkg::device_addr_t device_address,
    input  i2c_pkg::data_byte_t   register_address,
    input  i2c_pkg::data_byte_t   mosi_data,
    input  logic                  idle,
    input  i2c_pkg::frame_sel_t   frame_sel,
    output logic                  start,
    output logic                  is_read,
    output i2c_pkg::data_byte_t   tx_byte
);
    import i2c_pkg::*;

    device_addr_t req_device;
    data_byte_t   req_register;
    data_byte_t   req_data;
    logic         accept;

    // the sequencer is still idle while start is high
    assign accept = enable && idle && !start;

    always_ff @(posedge clock) begin
        if (accept) begin
            is_read      <= read_write;
            req_device   <= device_address;
            req_register <= register_address;
            req_data     <= mosi_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            start <= 1'b0;
        end
        else begin
            start <= accept;
        end
    end

    ////////////////////////////////////////
    // byte for the frame being set up
    ////////////////////////////////////////

    always_comb begin
        tx_byte = req_data;
        case (frame_sel)
            frame_addr_write: tx_byte = {req_device, 1'b0};
            frame_register:   tx_byte = req_register;
            frame_data:       tx_byte = req_data;
            frame_addr_read:  tx_byte = {req_device, 1'b1};
            default:          tx_byte = req_data;
        endcase
    end

endmodule

// ==== src/i2c_bus_sequencer.sv ====
`include "i2c_defs.svh"

module i2c_bus_sequencer (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                start,
    input  logic                is_read,
    input  i2c_pkg::data_byte_t tx_byte,
    input  i2c_pkg::divider_t   divider,
    input  logic                sda_in,
    output logic                idle,
    output logic                busy,
    output i2c_pkg::frame_sel_t frame_sel,
    output logic                bit_sample,
    output logic                read_done,
    output logic                ack_sample,
    output logic                ack_bit,
    output logic                scl_out,
    output logic                sda_out
);
    import i2c_pkg::*;

    localparam int phase_width = $clog2(`I2C_PHASES_PER_BIT);
    localparam int count_width = $clog2(`I2C_BYTE_WIDTH + 1);
    localparam logic [phase_width-1:0] last_phase = phase_width'(`I2C_PHASES_PER_BIT - 1);
    localparam logic [phase_width-1:0] sample_phase = last_phase - 1'b1;
    localparam logic [count_width-1:0] byte_bits = count_width'(`I2C_BYTE_WIDTH);

    seq_state_t             state;
    seq_state_t             state_next;
    seq_state_t             post_state;
    seq_state_t             post_state_next;
    frame_sel_t             frame_sel_next;
    divider_t               divider_count;
    logic                   tick;
    logic [phase_width-1:0] phase;
    logic [count_width-1:0] bit_count;
    logic [count_width-1:0] bit_count_next;
    data_byte_t             shift_reg;
    data_byte_t             shift_reg_next;
    logic                   scl;
    logic                   scl_next;
    logic                   sda;
    logic                   sda_next;
    logic                   ack_strobe;

    assign idle    = (state == st_idle);
    assign scl_out = scl;
    assign sda_out = sda;

    ////////////////////////////////////////
    // divider and quarter-bit phase
    ////////////////////////////////////////

    assign tick = (divider_count >= divider);

    always_ff @(posedge clock) begin
        if (!reset_n || idle) begin
            divider_count <= '0;
            phase         <= '0;
        end
        else begin
            divider_count <= tick ? '0 : divider_count + 1'b1;
            if (tick) begin
                phase <= (phase == last_phase) ? '0 : phase + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // transaction FSM
    ////////////////////////////////////////

    always_comb begin
        state_next      = state;
        post_state_next = post_state;
        frame_sel_next  = frame_sel;
        bit_count_next  = bit_count;
        shift_reg_next  = shift_reg;
        scl_next        = scl;
        sda_next        = sda;

        case (state)
            st_idle: begin
                scl_next       = 1'b1;
                sda_next       = 1'b1;
                frame_sel_next = frame_addr_write;
                if (start) begin
                    state_next = st_start;
                end
            end
            st_start: begin
                if (tick) begin
                    case (phase)
                        1: sda_next = 1'b0;
                        sample_phase: bit_count_next = byte_bits;
                        last_phase: begin
                            scl_next       = 1'b0;
                            sda_next       = tx_byte[`I2C_BYTE_WIDTH-1];
                            shift_reg_next = tx_byte << 1;
                            state_next     = st_shift_out;
                        end
                        default: ;
                    endcase
                end
            end
            st_shift_out: begin
                if (tick) begin
                    case (phase)
                        0: scl_next = 1'b1;
                        sample_phase: begin
                            scl_next       = 1'b0;
                            bit_count_next = bit_count - 1'b1;
                        end
                        last_phase: begin
                            if (bit_count == '0) begin
                                // release sda for the ack slot, line up the next frame
                                sda_next   = 1'b1;
                                state_next = st_check_ack;
                                case (frame_sel)
                                    frame_addr_write: begin
                                        frame_sel_next  = frame_register;
                                        post_state_next = st_shift_out;
                                    end
                                    frame_register: begin
                                        if (is_read) begin
                                            frame_sel_next  = frame_addr_read;
                                            post_state_next = st_restart;
                                        end
                                        else begin
                                            frame_sel_next  = frame_data;
                                            post_state_next = st_shift_out;
                                        end
                                    end
                                    frame_data: post_state_next = st_send_stop;
                                    default:    post_state_next = st_shift_in;
                                endcase
                            end
                            else begin
                                sda_next       = shift_reg[`I2C_BYTE_WIDTH-1];
                                shift_reg_next = shift_reg << 1;
                            end
                        end
                        default: ;
                    endcase
                end
            end
            st_check_ack: begin
                if (tick) begin
                    case (phase)
                        0: scl_next = 1'b1;
                        sample_phase: scl_next = 1'b0;
                        last_phase: begin
                            if (ack_bit) begin
                                // nack, straight to stop
                                sda_next   = 1'b0;
                                state_next = st_send_stop;
                            end
                            else begin
                                state_next     = post_state;
                                bit_count_next = byte_bits;
                                if (post_state == st_shift_out) begin
                                    sda_next       = tx_byte[`I2C_BYTE_WIDTH-1];
                                    shift_reg_next = tx_byte << 1;
                                end
                                else if (post_state == st_send_stop) begin
                                    sda_next = 1'b0;
                                end
                            end
                        end
                        default: ;
                    endcase
                end
            end
            st_restart: begin
                // scl comes up with sda released, start then pulls sda low
                if (tick) begin
                    case (phase)
                        1: scl_next = 1'b1;
                        last_phase: state_next = st_start;
                        default: ;
                    endcase
                end
            end
            st_shift_in: begin
                if (tick) begin
                    case (phase)
                        0: scl_next = 1'b1;
                        sample_phase: begin
                            scl_next       = 1'b0;
                            bit_count_next = bit_count - 1'b1;
                        end
                        last_phase: begin
                            if (bit_count == '0) begin
                                state_next = st_send_nack;
                            end
                        end
                        default: ;
                    endcase
                end
            end
            st_send_nack: begin
                if (tick) begin
                    case (phase)
                        0: scl_next = 1'b1;
                        sample_phase: scl_next = 1'b0;
                        last_phase: begin
                            sda_next   = 1'b0;
                            state_next = st_send_stop;
                        end
                        default: ;
                    endcase
                end
            end
            st_send_stop: begin
                if (tick) begin
                    case (phase)
                        0: scl_next = 1'b1;
                        sample_phase: sda_next = 1'b1;
                        last_phase: state_next = st_idle;
                        default: ;
                    endcase
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= st_idle;
            post_state <= st_idle;
            frame_sel  <= frame_addr_write;
            bit_count  <= '0;
            scl        <= 1'b1;
            sda        <= 1'b1;
            busy       <= 1'b0;
        end
        else begin
            state      <= state_next;
            post_state <= post_state_next;
            frame_sel  <= frame_sel_next;
            bit_count  <= bit_count_next;
            scl        <= scl_next;
            sda        <= sda_next;
            busy       <= (state_next != st_idle);
        end
    end

    always_ff @(posedge clock) begin
        shift_reg <= shift_reg_next;
    end

    ////////////////////////////////////////
    // strobes to the read collector
    ////////////////////////////////////////

    assign bit_sample = (state == st_shift_in) && tick && (phase == sample_phase);
    assign read_done  = (state == st_shift_in) && tick && (phase == last_phase)
                        && (bit_count == '0);
    assign ack_strobe = (state == st_check_ack) && tick && (phase == sample_phase);

    // sda sampled while scl is still high
    always_ff @(posedge clock) begin
        if (ack_strobe) begin
            ack_bit <= sda_in;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            ack_sample <= 1'b0;
        end
        else begin
            ack_sample <= ack_strobe;
        end
    end

endmodule

// ==== src/i2c_read_collector.sv ====
`include "i2c_defs.svh"

module i2c_read_collector (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                start,
    input  logic                bit_sample,
    input  logic                sda_in,
    input  logic                read_done,
    input  logic                ack_sample,
    input  logic                ack_bit,
    output i2c_pkg::data_byte_t miso_data,
    output logic                ack_error
);
    import i2c_pkg::*;

    data_byte_t read_shift;

    // msb arrives first
    always_ff @(posedge clock) begin
        if (bit_sample) begin
            read_shift <= {read_shift[`I2C_BYTE_WIDTH-2:0], sda_in};
        end
    end

    ////////////////////////////////////////
    // published results
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            miso_data <= '0;
            ack_error <= 1'b0;
        end
        else begin
            // whole byte only
            if (read_done) begin
                miso_data <= read_shift;
            end
            if (start) begin
                ack_error <= 1'b0;
            end
            else if (ack_sample && ack_bit) begin
                ack_error <= 1'b1;
            end
        end
    end

endmodule

// ==== src/i2c_master.sv ====
module i2c_master (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  enable,
    input  logic                  read_write,
    input  i2c_pkg::device_addr_t device_address,
    input  i2c_pkg::data_byte_t   register_address,
    input  i2c_pkg::data_byte_t   mosi_data,
    input  i2c_pkg::divider_t     divider,
    input  logic                  sda_in,
    output i2c_pkg::data_byte_t   miso_data,
    output logic                  busy,
    output logic                  ack_error,
    output logic                  scl_out,
    output logic                  sda_out
);
    import i2c_pkg::*;

    logic       start;
    logic       is_read;
    data_byte_t tx_byte;
    logic       idle;
    frame_sel_t frame_sel;
    logic       bit_sample;
    logic       read_done;
    logic       ack_sample;
    logic       ack_bit;

    i2c_request_decoder i_decoder (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .mosi_data        (mosi_data),
        .idle             (idle),
        .frame_sel        (frame_sel),
        .start            (start),
        .is_read          (is_read),
        .tx_byte          (tx_byte)
    );

    i2c_bus_sequencer i_sequencer (
        .clock      (clock),
        .reset_n    (reset_n),
        .start      (start),
        .is_read    (is_read),
        .tx_byte    (tx_byte),
        .divider    (divider),
        .sda_in     (sda_in),
        .idle       (idle),
        .busy       (busy),
        .frame_sel  (frame_sel),
        .bit_sample (bit_sample),
        .read_done  (read_done),
        .ack_sample (ack_sample),
        .ack_bit    (ack_bit),
        .scl_out    (scl_out),
        .sda_out    (sda_out)
    );

    i2c_read_collector i_collector (
        .clock      (clock),
        .reset_n    (reset_n),
        .start      (start),
        .bit_sample (bit_sample),
        .sda_in     (sda_in),
        .read_done  (read_done),
        .ack_sample (ack_sample),
        .ack_bit    (ack_bit),
        .miso_data  (miso_data),
        .ack_error  (ack_error)
    );

endmodule

// ==== dv/i2c_master_properties.sv ====
module i2c_master_properties (
    input logic clock,
    input logic reset_n,
    input logic enable,
    input logic busy,
    input logic ack_error,
    input logic scl_out,
    input logic sda_out
);
    timeunit 1ns;
    timeprecision 1ps;

    // both lines released between transactions
    idle_bus_released: assert property (@(posedge clock) disable iff (!reset_n)
        !busy |-> (scl_out && sda_out))
        else $error("bus line driven low while busy is low");

    ack_error_only_when_busy: assert property (@(posedge clock) disable iff (!reset_n)
        $changed(ack_error) |-> busy)
        else $error("ack_error changed while busy is low");

    // busy rises two samples after the enable that started it
    busy_needs_enable: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(busy) |-> $past(enable, 2))
        else $error("busy rose without an accepted enable");

endmodule

bind i2c_master i2c_master_properties i_properties (
    .clock     (clock),
    .reset_n   (reset_n),
    .enable    (enable),
    .busy      (busy),
    .ack_error (ack_error),
    .scl_out   (scl_out),
    .sda_out   (sda_out)
);

// ==== dv/i2c_master_tb.sv ====
`include "i2c_defs.svh"

module i2c_master_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import i2c_pkg::*;

    localparam int max_wait_cycles = 5000;

    // divider 0 in a row means a random divider from 1 to 6
    // nack_frame is 0 for none, 1 for the address frame, 2 for the register frame
    typedef struct packed {
        logic             read_write;
        device_addr_t     device_address;
        data_byte_t       register_address;
        data_byte_t       mosi_data;
        divider_t         divider;
        logic [1:0]       nack_frame;
        data_byte_t       slave_value;
        logic             poke_busy;
        logic [1:0]       exp_count;
        data_byte_t [0:2] exp_bytes;
        data_byte_t       exp_miso;
        logic             exp_ack_error;
    } row_t;

    logic         clock;
    logic         reset_n;
    logic         enable;
    logic         read_write;
    device_addr_t device_address;
    data_byte_t   register_address;
    data_byte_t   mosi_data;
    divider_t     divider;
    logic         sda_in;
    data_byte_t   miso_data;
    logic         busy;
    logic         ack_error;
    logic         scl_out;
    logic         sda_out;

    row_t         rows [$];
    string        names [$];
    logic [1:0]   cur_nack;
    data_byte_t   cur_read_value;

    // slave side of the bus
    logic         slave_sda = 1'b1;
    logic         scl_seen = 1'b1;
    logic         sda_seen = 1'b1;
    logic         in_transfer = 1'b0;
    logic         sending = 1'b0;
    logic         addr_next = 1'b0;
    int           bit_count = 0;
    data_byte_t   shift_byte = '0;
    data_byte_t   captured [4];
    int           captured_count = 0;
    logic         restart_seen = 1'b0;
    logic         stop_seen = 1'b0;
    logic         master_ack = 1'b0;
    logic         scl_line;
    logic         sda_line;

    // only the master drives scl
    // sda is the wired-AND of both sides
    assign scl_line = scl_out;
    assign sda_line = sda_out & slave_sda;
    assign sda_in   = sda_line;

    i2c_master i_dut (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .mosi_data        (mosi_data),
        .divider          (divider),
        .sda_in           (sda_in),
        .miso_data        (miso_data),
        .busy             (busy),
        .ack_error        (ack_error),
        .scl_out          (scl_out),
        .sda_out          (sda_out)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    ////////////////////////////////////////
    // slave model
    ////////////////////////////////////////

    always @(negedge clock) begin
        if (scl_seen && scl_line && sda_seen && !sda_line) begin
            // start or repeated start
            if (in_transfer) begin
                restart_seen <= 1'b1;
            end
            else begin
                captured_count <= 0;
                restart_seen   <= 1'b0;
                stop_seen      <= 1'b0;
                master_ack     <= 1'b0;
            end
            in_transfer <= 1'b1;
            addr_next   <= 1'b1;
            bit_count   <= 0;
            sending     <= 1'b0;
            slave_sda   <= 1'b1;
        end
        else if (scl_seen && scl_line && !sda_seen && sda_line) begin
            in_transfer <= 1'b0;
            stop_seen   <= 1'b1;
            slave_sda   <= 1'b1;
        end
        else if (!scl_seen && scl_line) begin
            if (bit_count < `I2C_BYTE_WIDTH) begin
                shift_byte <= {shift_byte[`I2C_BYTE_WIDTH-2:0], sda_line};
            end
            else if (sending) begin
                master_ack <= sda_line;
            end
            bit_count <= bit_count + 1;
        end
        else if (scl_seen && !scl_line) begin
            if (bit_count == `I2C_BYTE_WIDTH) begin
                if (sending) begin
                    slave_sda <= 1'b1;
                end
                else begin
                    captured[captured_count] <= shift_byte;
                    captured_count           <= captured_count + 1;
                    slave_sda <= (captured_count + 1 == int'(cur_nack));
                end
            end
            else if (bit_count == `I2C_BYTE_WIDTH + 1) begin
                // a read address turns the slave around after its ack slot
                bit_count <= 0;
                addr_next <= 1'b0;
                if (addr_next && shift_byte[0] && !slave_sda) begin
                    sending   <= 1'b1;
                    slave_sda <= cur_read_value[`I2C_BYTE_WIDTH-1];
                end
                else begin
                    sending   <= 1'b0;
                    slave_sda <= 1'b1;
                end
            end
            else if (sending) begin
                slave_sda <= cur_read_value[`I2C_BYTE_WIDTH-1-bit_count];
            end
        end
        scl_seen <= scl_line;
        sda_seen <= sda_line;
    end

    ////////////////////////////////////////
    // checks and waits
    ////////////////////////////////////////

    task automatic check_byte(input string name, input string what,
                              input data_byte_t expected, input data_byte_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s, %s: expected %h, actual %h", name, what, expected, actual);
            $display("TB FAILED");
            $fatal(1, "byte check failed");
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch in %s, %s: expected %b, actual %b", name, what, expected, actual);
            $display("TB FAILED");
            $fatal(1, "flag check failed");
        end
    endtask

    task automatic wait_for_busy(input string name, input logic level);
        int cycles;
        cycles = 0;
        while (busy !== level) begin
            @(negedge clock);
            cycles++;
            if (cycles > max_wait_cycles) begin
                $display("%s: busy never went to %b", name, level);
                $display("TB FAILED");
                $fatal(1, "timeout waiting for busy");
            end
        end
    endtask

    task automatic add_row(input string name, input row_t row);
        names.push_back(name);
        rows.push_back(row);
    endtask

    task automatic build_table();
        // name, rw, dev, reg, data, divider, nack, slave value, poke
        //       count, expected bytes, miso, ack_error
        add_row("write_basic", '{1'b0, 7'h50, 8'h1a, 8'h5c, 16'd3, 2'd0, 8'h00, 1'b0,
                2'd3, {8'ha0, 8'h1a, 8'h5c}, 8'h00, 1'b0});
        add_row("read_basic", '{1'b1, 7'h50, 8'h2b, 8'h00, 16'd2, 2'd0, 8'hc3, 1'b0,
                2'd3, {8'ha0, 8'h2b, 8'ha1}, 8'hc3, 1'b0});
        add_row("nack_address", '{1'b0, 7'h31, 8'h10, 8'h77, 16'd2, 2'd1, 8'h00, 1'b0,
                2'd1, {8'h62, 8'h00, 8'h00}, 8'hc3, 1'b1});
        add_row("write_after_nack", '{1'b0, 7'h31, 8'h10, 8'h77, 16'd1, 2'd0, 8'h00, 1'b0,
                2'd3, {8'h62, 8'h10, 8'h77}, 8'hc3, 1'b0});
        add_row("nack_register", '{1'b1, 7'h44, 8'h08, 8'h00, 16'd3, 2'd2, 8'hff, 1'b0,
                2'd2, {8'h88, 8'h08, 8'h00}, 8'hc3, 1'b1});
        add_row("read_after_nack", '{1'b1, 7'h44, 8'h08, 8'h00, 16'd1, 2'd0, 8'h5a, 1'b0,
                2'd3, {8'h88, 8'h08, 8'h89}, 8'h5a, 1'b0});
        add_row("enable_while_busy", '{1'b0, 7'h12, 8'h34, 8'h56, 16'd2, 2'd0, 8'h00, 1'b1,
                2'd3, {8'h24, 8'h34, 8'h56}, 8'h5a, 1'b0});
        add_row("random_write", '{1'b0, 7'h50, 8'h1a, 8'h5c, 16'd0, 2'd0, 8'h00, 1'b0,
                2'd3, {8'ha0, 8'h1a, 8'h5c}, 8'h5a, 1'b0});
        add_row("random_read", '{1'b1, 7'h50, 8'h2b, 8'h00, 16'd0, 2'd0, 8'hc3, 1'b0,
                2'd3, {8'ha0, 8'h2b, 8'ha1}, 8'hc3, 1'b0});
        add_row("random_nack_register", '{1'b0, 7'h31, 8'h10, 8'h77, 16'd0, 2'd2, 8'h00, 1'b0,
                2'd2, {8'h62, 8'h10, 8'h00}, 8'hc3, 1'b1});
    endtask

    task automatic run_row(input string name, input row_t row);
        logic full_read;
        full_read        = row.read_write && (row.nack_frame == 2'd0);
        cur_nack         = row.nack_frame;
        cur_read_value   = row.slave_value;
        read_write       = row.read_write;
        device_address   = row.device_address;
        register_address = row.register_address;
        mosi_data        = row.mosi_data;
        divider          = row.divider;
        enable           = 1'b1;
        @(negedge clock);
        enable = 1'b0;
        wait_for_busy(name, 1'b1);
        if (row.poke_busy) begin
            // a request with other fields must be ignored
            @(negedge clock);
            enable           = 1'b1;
            read_write       = ~row.read_write;
            device_address   = 7'h7f;
            register_address = 8'hff;
            mosi_data        = 8'hff;
            @(negedge clock);
            enable = 1'b0;
        end
        wait_for_busy(name, 1'b0);
        check_flag(name, "stop seen", 1'b1, stop_seen);
        check_byte(name, "frames captured", data_byte_t'(row.exp_count),
                   data_byte_t'(captured_count));
        for (int k = 0; k < int'(row.exp_count); k++) begin
            check_byte(name, $sformatf("frame %0d", k), row.exp_bytes[k], captured[k]);
        end
        check_flag(name, "repeated start", full_read, restart_seen);
        if (full_read) begin
            check_flag(name, "master sda in ninth slot", 1'b1, master_ack);
        end
        check_byte(name, "miso_data", row.exp_miso, miso_data);
        check_flag(name, "ack_error", row.exp_ack_error, ack_error);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        row_t row;
        int   i;
        void'($urandom(32'h2e8c));
        reset_n          = 1'b0;
        enable           = 1'b0;
        read_write       = 1'b0;
        device_address   = '0;
        register_address = '0;
        mosi_data        = '0;
        divider          = 16'd3;
        cur_nack         = 2'd0;
        cur_read_value   = '0;
        build_table();
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        check_flag("reset", "busy", 1'b0, busy);
        check_flag("reset", "ack_error", 1'b0, ack_error);
        check_flag("reset", "scl_out", 1'b1, scl_out);
        check_flag("reset", "sda_out", 1'b1, sda_out);
        check_byte("reset", "miso_data", 8'h00, miso_data);
        for (i = 0; i < rows.size(); i++) begin
            row = rows[i];
            if (row.divider == '0) begin
                row.divider = divider_t'(32'd1 + ($urandom % 6));
            end
            run_row(names[i], row);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== i2c_master.f ====
+incdir+include
src/i2c_pkg.sv
src/i2c_request_decoder.sv
src/i2c_bus_sequencer.sv
src/i2c_read_collector.sv
src/i2c_master.sv
dv/i2c_master_properties.sv
dv/i2c_master_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the i2c master testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module i2c_master_tb -f i2c_master.f \
    --Mdir obj_dir -o sim_i2c_master
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_i2c_master
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
